// File: include/lint_params.svh
// ********************
// lint test design constants
// bus widths, register map, RAM window codes
// ********************

`ifndef LINT_PARAMS_SVH
`define LINT_PARAMS_SVH

`define LINT_ADDR_W   20
`define DATA_W        32
`define BE_W          4
`define RAM_ADDR_W    12
`define GPIO_W        80
`define EVENT_W       16

// register offsets as full bus addresses
`define REG_RAM_CTRL  20'h00020
`define REG_GPIO_OUT0 20'h00040
`define REG_GPIO_OUT1 20'h00044
`define REG_GPIO_OUT2 20'h00048  // only 16 bits stored
`define REG_GPIO_OE0  20'h00050
`define REG_GPIO_OE1  20'h00054
`define REG_GPIO_OE2  20'h00058  // only 16 bits stored
`define REG_GPIO_IN0  20'h00060
`define REG_GPIO_IN1  20'h00064
`define REG_GPIO_IN2  20'h00068
`define REG_EVENTS    20'h0006c
`define REG_SIGNATURE 20'h00800

`define WIN_OPER0     8'h01  // address bits 19:12
`define WIN_OPER1     8'h02
`define WIN_COEF      8'h03

`define SIGNATURE     32'hca11ef3a
`define VERSION       8'h55

`endif

// File: source/lint_pkg.sv
// ********************
// lint test design types
// bus request/response, RAM mode and RAM port bundles
// ********************

`include "lint_params.svh"

package lint_pkg;

  typedef enum logic [1:0] {
    lane_word     = 2'd0,
    lane_half     = 2'd1,
    lane_byte     = 2'd2,
    lane_word_alt = 2'd3
  } lane_mode_e;

  typedef struct packed {
    logic                    req;
    logic                    wen;    // low for write
    logic [`LINT_ADDR_W-1:0] addr;
    logic [`DATA_W-1:0]      wdata;
    logic [`BE_W-1:0]        be;
  } lint_req_t;

  typedef struct packed {
    logic               gnt;
    logic               valid;
    logic [`DATA_W-1:0] rdata;
  } lint_rsp_t;

  typedef struct packed {
    logic [16:0] rsvd;         // unused upper bits
    logic        coef_wdsel;
    logic        oper1_wdsel;
    logic        oper0_wdsel;
    lane_mode_e  coef_wmode;
    lane_mode_e  coef_rmode;
    lane_mode_e  oper1_wmode;
    lane_mode_e  oper1_rmode;
    lane_mode_e  oper0_wmode;
    lane_mode_e  oper0_rmode;  // bits 1:0
  } ram_mode_t;

  typedef struct packed {
    logic [`RAM_ADDR_W-1:0] waddr;
    logic                   we;
    logic [`DATA_W-1:0]     wdata;
  } ram_wr_t;

  typedef struct packed {
    logic [`RAM_ADDR_W-1:0] raddr;
  } ram_rd_t;

  typedef struct packed {
    logic                    wr_stb;   // WRITE cycle
    logic                    rd_stb;   // READ cycle
    logic                    rd_done;  // READ_WAIT cycle
    logic [`LINT_ADDR_W-1:0] addr;
    logic [`DATA_W-1:0]      wdata;
  } bus_cmd_t;

endpackage

// File: source/lint_slave_fsm.sv
// ********************
// lint bus slave
// request edge detect, IDLE/WRITE/READ/READ_WAIT FSM,
// grant/valid pulses and the read data register
// ********************

`timescale 1ns/100ps

`include "lint_params.svh"

module lint_slave_fsm
  import lint_pkg::*;
(
  input  logic               CLK,
  input  logic               arst_n,
  input  lint_req_t          bus_req,
  input  logic [`DATA_W-1:0] reg_rdata,
  input  logic [`DATA_W-1:0] ram_rdata,
  input  logic               ram_hit,
  output lint_rsp_t          bus_rsp,
  output bus_cmd_t           cmd,
  output logic               req_seen
);

  typedef enum logic [1:0] {
    st_idle,
    st_write,
    st_read,
    st_read_wait
  } state_e;

  state_e             state;
  logic               req_q;    // req from last cycle
  logic               gnt_q;
  logic               valid_q;
  logic [`DATA_W-1:0] rdata_q;

  // new request only on a rising req edge with no grant pending
  assign req_seen = (state == st_idle) & bus_req.req & ~req_q & ~gnt_q;

  assign cmd.wr_stb  = (state == st_write);
  assign cmd.rd_stb  = (state == st_read);
  assign cmd.rd_done = (state == st_read_wait);
  assign cmd.addr    = bus_req.addr;   // held by master until valid
  assign cmd.wdata   = bus_req.wdata;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state   <= st_idle;
      req_q   <= 1'b0;
      gnt_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      req_q   <= bus_req.req;
      valid_q <= gnt_q;  // valid trails gnt by one cycle
      gnt_q   <= 1'b0;
      case (state)
        st_idle: begin
          if (req_seen) begin
            if (!bus_req.wen) begin
              gnt_q <= 1'b1;  // writes are granted right away
              state <= st_write;
            end else begin
              state <= st_read;
            end
          end
        end
        st_write: state <= st_idle;
        st_read:  state <= st_read_wait;
        st_read_wait: begin
          gnt_q <= 1'b1;
          state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // register word first, RAM word overrides it one cycle later on a window hit
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      rdata_q <= '1;
    end else if (cmd.rd_stb) begin
      rdata_q <= reg_rdata;
    end else if (cmd.rd_done && ram_hit) begin
      rdata_q <= ram_rdata;
    end
  end

  assign bus_rsp.gnt   = gnt_q;
  assign bus_rsp.valid = valid_q;
  assign bus_rsp.rdata = rdata_q;

endmodule

// File: source/gpio_reg_bank.sv
// ********************
// GPIO register bank
// output/enable, event and RAM mode registers,
// GPIO input views and signature read back
// ********************

`timescale 1ns/100ps

`include "lint_params.svh"

module gpio_reg_bank
  import lint_pkg::*;
(
  input  logic                CLK,
  input  logic                arst_n,
  input  bus_cmd_t            cmd,
  input  logic [`GPIO_W-1:0]  gpio_in,
  output logic [`GPIO_W-1:0]  gpio_out,
  output logic [`GPIO_W-1:0]  gpio_oe,
  output logic [`EVENT_W-1:0] events,
  output ram_mode_t           ram_mode,
  output logic [`DATA_W-1:0]  reg_rdata
);

  logic [`GPIO_W-1:0]  out_q;
  logic [`GPIO_W-1:0]  oe_q;
  logic [`EVENT_W-1:0] events_q;
  ram_mode_t           mode_q;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      out_q    <= '0;
      oe_q     <= '0;
      events_q <= '0;
      mode_q   <= '0;
    end else if (cmd.wr_stb) begin
      case (cmd.addr)
        `REG_RAM_CTRL:  mode_q             <= cmd.wdata;
        `REG_GPIO_OUT0: out_q[31:0]        <= cmd.wdata;
        `REG_GPIO_OUT1: out_q[63:32]       <= cmd.wdata;
        `REG_GPIO_OUT2: out_q[`GPIO_W-1:64] <= cmd.wdata[15:0];
        `REG_GPIO_OE0:  oe_q[31:0]         <= cmd.wdata;
        `REG_GPIO_OE1:  oe_q[63:32]        <= cmd.wdata;
        `REG_GPIO_OE2:  oe_q[`GPIO_W-1:64]  <= cmd.wdata[15:0];
        `REG_EVENTS:    events_q           <= cmd.wdata[`EVENT_W-1:0];
        default: ;  // window and unmapped writes land elsewhere or nowhere
      endcase
    end
  end

  // read mux with zero for unmapped offsets
  always_comb begin
    reg_rdata = '0;
    case (cmd.addr)
      `REG_RAM_CTRL:  reg_rdata = mode_q;
      `REG_GPIO_OUT0: reg_rdata = out_q[31:0];
      `REG_GPIO_OUT1: reg_rdata = out_q[63:32];
      `REG_GPIO_OUT2: reg_rdata = {16'b0, out_q[`GPIO_W-1:64]};
      `REG_GPIO_OE0:  reg_rdata = oe_q[31:0];
      `REG_GPIO_OE1:  reg_rdata = oe_q[63:32];
      `REG_GPIO_OE2:  reg_rdata = {16'b0, oe_q[`GPIO_W-1:64]};
      `REG_GPIO_IN0:  reg_rdata = gpio_in[31:0];
      `REG_GPIO_IN1:  reg_rdata = gpio_in[63:32];
      `REG_GPIO_IN2:  reg_rdata = {16'b0, gpio_in[`GPIO_W-1:64]};
      `REG_EVENTS:    reg_rdata = {16'b0, events_q};
      `REG_SIGNATURE: reg_rdata = `SIGNATURE;
      default:        reg_rdata = '0;
    endcase
  end

  assign gpio_out = out_q;
  assign gpio_oe  = oe_q;
  assign events   = events_q;
  assign ram_mode = mode_q;

endmodule

// File: source/ram_window.sv
// ********************
// RAM address windows
// oper0/oper1/coef decode, lane packing on write,
// lane alignment on read
// ********************

`timescale 1ns/100ps

`include "lint_params.svh"

module ram_window
  import lint_pkg::*;
(
  input  logic               CLK,
  input  logic               arst_n,
  input  bus_cmd_t           cmd,
  input  logic               req_accept,
  input  ram_mode_t          ram_mode,
  input  logic [`DATA_W-1:0] oper0_rdata,
  input  logic [`DATA_W-1:0] oper1_rdata,
  input  logic [`DATA_W-1:0] coef_rdata,
  output ram_wr_t            oper0_wr,
  output ram_wr_t            oper1_wr,
  output ram_wr_t            coef_wr,
  output ram_rd_t            oper0_rd,
  output ram_rd_t            oper1_rd,
  output ram_rd_t            coef_rd,
  output logic [`DATA_W-1:0] ram_rdata,
  output logic               ram_hit
);

  logic [2:0]             win_hit;      // 0 oper0, 1 oper1, 2 coef
  logic [1:0]             lane;
  lane_mode_e             wmode [3];
  lane_mode_e             rmode [3];
  logic [`DATA_W-1:0]     rdata_in [3];
  logic [2:0]             we_q;
  logic [`RAM_ADDR_W-1:0] waddr_q [3];
  logic [`DATA_W-1:0]     wdata_q [3];
  logic [`RAM_ADDR_W-1:0] raddr_q [3];

  // write lane moved down to bit 0
  function automatic logic [`DATA_W-1:0] pack_wdata(lane_mode_e mode, logic [1:0] sel,
                                                    logic [`DATA_W-1:0] data);
    logic [`DATA_W-1:0] res;
    case (mode)
      lane_half: res = sel[1] ? {16'b0, data[31:16]} : data;
      lane_byte: res = {24'b0, data[8*sel +: 8]};
      default:   res = data;  // word and word_alt
    endcase
    return res;
  endfunction

  // read word shifted up to the addressed lane
  function automatic logic [`DATA_W-1:0] align_rdata(lane_mode_e mode, logic [1:0] sel,
                                                     logic [`DATA_W-1:0] data);
    logic [`DATA_W-1:0] res;
    case (mode)
      lane_half: res = sel[1] ? {data[15:0], 16'b0} : data;
      lane_byte: res = data << (8 * sel);
      default:   res = data;
    endcase
    return res;
  endfunction

  assign win_hit[0] = (cmd.addr[`LINT_ADDR_W-1:`RAM_ADDR_W] == `WIN_OPER0);
  assign win_hit[1] = (cmd.addr[`LINT_ADDR_W-1:`RAM_ADDR_W] == `WIN_OPER1);
  assign win_hit[2] = (cmd.addr[`LINT_ADDR_W-1:`RAM_ADDR_W] == `WIN_COEF);
  assign lane       = cmd.addr[1:0];

  assign wmode[0] = ram_mode.oper0_wmode;
  assign wmode[1] = ram_mode.oper1_wmode;
  assign wmode[2] = ram_mode.coef_wmode;
  assign rmode[0] = ram_mode.oper0_rmode;
  assign rmode[1] = ram_mode.oper1_rmode;
  assign rmode[2] = ram_mode.coef_rmode;
  assign rdata_in[0] = oper0_rdata;
  assign rdata_in[1] = oper1_rdata;
  assign rdata_in[2] = coef_rdata;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      we_q <= '0;
      for (int i = 0; i < 3; i++) raddr_q[i] <= '0;
    end else begin
      we_q <= {3{cmd.wr_stb}} & win_hit;  // single cycle pulse
      for (int i = 0; i < 3; i++) begin
        if (req_accept && win_hit[i]) raddr_q[i] <= cmd.addr[`RAM_ADDR_W-1:0];
      end
    end
  end

  always_ff @(posedge CLK) begin
    for (int i = 0; i < 3; i++) begin
      if (cmd.wr_stb && win_hit[i]) begin
        waddr_q[i] <= cmd.addr[`RAM_ADDR_W-1:0];
        wdata_q[i] <= pack_wdata(wmode[i], lane, cmd.wdata);
      end
    end
  end

  always_comb begin
    ram_rdata = '0;
    for (int i = 0; i < 3; i++) begin
      if (win_hit[i]) ram_rdata = align_rdata(rmode[i], lane, rdata_in[i]);
    end
  end

  assign ram_hit = cmd.rd_done & (|win_hit);

  assign oper0_wr = '{waddr: waddr_q[0], we: we_q[0], wdata: wdata_q[0]};
  assign oper1_wr = '{waddr: waddr_q[1], we: we_q[1], wdata: wdata_q[1]};
  assign coef_wr  = '{waddr: waddr_q[2], we: we_q[2], wdata: wdata_q[2]};
  assign oper0_rd = '{raddr: raddr_q[0]};
  assign oper1_rd = '{raddr: raddr_q[1]};
  assign coef_rd  = '{raddr: raddr_q[2]};

endmodule

// File: source/efpga_test_top.sv
// ********************
// eFPGA test design top
// lint slave, GPIO registers, RAM windows, pin loops
// ********************

`timescale 1ns/100ps

`include "lint_params.svh"

module efpga_test_top
  import lint_pkg::*;
(
  input  logic                CLK,
  input  logic                arst_n,
  input  lint_req_t           bus_req,
  input  logic [`GPIO_W-1:0]  gpio_in,
  input  logic [`DATA_W-1:0]  control_in,
  input  logic [`DATA_W-1:0]  oper0_rdata,
  input  logic [`DATA_W-1:0]  oper1_rdata,
  input  logic [`DATA_W-1:0]  coef_rdata,
  output lint_rsp_t           bus_rsp,
  output logic [`GPIO_W-1:0]  gpio_out,
  output logic [`GPIO_W-1:0]  gpio_oe,
  output logic [`EVENT_W-1:0] events,
  output logic [`DATA_W-1:0]  status_out,
  output logic [7:0]          version,
  output ram_wr_t             oper0_wr,
  output ram_wr_t             oper1_wr,
  output ram_wr_t             coef_wr,
  output ram_rd_t             oper0_rd,
  output ram_rd_t             oper1_rd,
  output ram_rd_t             coef_rd
);

  bus_cmd_t           cmd;
  ram_mode_t          ram_mode;
  logic [`DATA_W-1:0] reg_rdata;
  logic [`DATA_W-1:0] ram_rdata;
  logic               ram_hit;
  logic               req_seen;

  assign version    = `VERSION;
  assign status_out = ~control_in;  // loop-back test of the control pins

  lint_slave_fsm u_slave (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .bus_req   (bus_req),
    .reg_rdata (reg_rdata),
    .ram_rdata (ram_rdata),
    .ram_hit   (ram_hit),
    .bus_rsp   (bus_rsp),
    .cmd       (cmd),
    .req_seen  (req_seen)
  );

  gpio_reg_bank u_regs (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .cmd       (cmd),
    .gpio_in   (gpio_in),
    .gpio_out  (gpio_out),
    .gpio_oe   (gpio_oe),
    .events    (events),
    .ram_mode  (ram_mode),
    .reg_rdata (reg_rdata)
  );

  ram_window u_ram (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .cmd         (cmd),
    .req_accept  (req_seen),
    .ram_mode    (ram_mode),
    .oper0_rdata (oper0_rdata),
    .oper1_rdata (oper1_rdata),
    .coef_rdata  (coef_rdata),
    .oper0_wr    (oper0_wr),
    .oper1_wr    (oper1_wr),
    .coef_wr     (coef_wr),
    .oper0_rd    (oper0_rd),
    .oper1_rd    (oper1_rd),
    .coef_rd     (coef_rd),
    .ram_rdata   (ram_rdata),
    .ram_hit     (ram_hit)
  );

endmodule

// File: test/ram_model.sv
// ********************
// behavioural RAM model
// three 4096-word RAMs with one-cycle registered read
// ********************

`timescale 1ns/100ps

`include "lint_params.svh"

module ram_model
  import lint_pkg::*;
(
  input  logic               CLK,
  input  ram_wr_t            oper0_wr,
  input  ram_wr_t            oper1_wr,
  input  ram_wr_t            coef_wr,
  input  ram_rd_t            oper0_rd,
  input  ram_rd_t            oper1_rd,
  input  ram_rd_t            coef_rd,
  output logic [`DATA_W-1:0] oper0_rdata,
  output logic [`DATA_W-1:0] oper1_rdata,
  output logic [`DATA_W-1:0] coef_rdata
);

  localparam int depth = 1 << `RAM_ADDR_W;

  logic [`DATA_W-1:0] oper0_mem [depth];
  logic [`DATA_W-1:0] oper1_mem [depth];
  logic [`DATA_W-1:0] coef_mem [depth];

  initial begin
    for (int i = 0; i < depth; i++) begin
      oper0_mem[i] = {20'ha0000, i[11:0]};  // word address in low bits
      oper1_mem[i] = {20'hb0000, i[11:0]};
      coef_mem[i]  = {20'hc0000, i[11:0]};
    end
    oper0_rdata = '0;
    oper1_rdata = '0;
    coef_rdata  = '0;
  end

  always @(posedge CLK) begin
    if (oper0_wr.we) oper0_mem[oper0_wr.waddr] <= oper0_wr.wdata;
    if (oper1_wr.we) oper1_mem[oper1_wr.waddr] <= oper1_wr.wdata;
    if (coef_wr.we) coef_mem[coef_wr.waddr] <= coef_wr.wdata;
    oper0_rdata <= oper0_mem[oper0_rd.raddr];  // old data on same-cycle write
    oper1_rdata <= oper1_mem[oper1_rd.raddr];
    coef_rdata  <= coef_mem[coef_rd.raddr];
  end

endmodule

// File: test/tb_efpga_test_top.sv
// ********************
// eFPGA test design testbench
// directed tests of the lint bus, GPIO registers,
// RAM windows and pin loops
// ********************

`timescale 1ns/100ps

`include "lint_params.svh"

module tb_efpga_test_top
  import lint_pkg::*;
();

  localparam int timeout_cycles = 20;

  logic                CLK;
  logic                arst_n;
  lint_req_t           bus_req;
  lint_rsp_t           bus_rsp;
  logic [`GPIO_W-1:0]  gpio_in;
  logic [`GPIO_W-1:0]  gpio_out;
  logic [`GPIO_W-1:0]  gpio_oe;
  logic [`EVENT_W-1:0] events;
  logic [`DATA_W-1:0]  control_in;
  logic [`DATA_W-1:0]  status_out;
  logic [7:0]          version;
  ram_wr_t             oper0_wr;
  ram_wr_t             oper1_wr;
  ram_wr_t             coef_wr;
  ram_rd_t             oper0_rd;
  ram_rd_t             oper1_rd;
  ram_rd_t             coef_rd;
  logic [`DATA_W-1:0]  oper0_rdata;
  logic [`DATA_W-1:0]  oper1_rdata;
  logic [`DATA_W-1:0]  coef_rdata;
  int                  last_lat;  // gnt delay of the last transfer
  logic [7:0]          win_code [3] = '{`WIN_OPER0, `WIN_OPER1, `WIN_COEF};

  always #20 CLK = ~CLK;

  efpga_test_top u_dut (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .bus_req     (bus_req),
    .gpio_in     (gpio_in),
    .control_in  (control_in),
    .oper0_rdata (oper0_rdata),
    .oper1_rdata (oper1_rdata),
    .coef_rdata  (coef_rdata),
    .bus_rsp     (bus_rsp),
    .gpio_out    (gpio_out),
    .gpio_oe     (gpio_oe),
    .events      (events),
    .status_out  (status_out),
    .version     (version),
    .oper0_wr    (oper0_wr),
    .oper1_wr    (oper1_wr),
    .coef_wr     (coef_wr),
    .oper0_rd    (oper0_rd),
    .oper1_rd    (oper1_rd),
    .coef_rd     (coef_rd)
  );

  ram_model u_ram (
    .CLK         (CLK),
    .oper0_wr    (oper0_wr),
    .oper1_wr    (oper1_wr),
    .coef_wr     (coef_wr),
    .oper0_rd    (oper0_rd),
    .oper1_rd    (oper1_rd),
    .coef_rd     (coef_rd),
    .oper0_rdata (oper0_rdata),
    .oper1_rdata (oper1_rdata),
    .coef_rdata  (coef_rdata)
  );

  task automatic check_eq(input logic [`GPIO_W-1:0] got, input logic [`GPIO_W-1:0] exp,
                          input string what);
    assert (got === exp) else begin
      $display("mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
      $display("sim failed");
      $fatal(1, "check failed");
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("sim failed");
    $fatal(1, "wait expired");
  endtask

  // one bus access that leaves req high after valid when keep_req is set
  task automatic run_transfer(input logic write, input logic [`LINT_ADDR_W-1:0] addr,
                              input logic [`DATA_W-1:0] wdata, input logic keep_req,
                              output logic [`DATA_W-1:0] rdata);
    int cycles;
    @(posedge CLK);
    bus_req.req   <= 1'b1;
    bus_req.wen   <= ~write;
    bus_req.addr  <= addr;
    bus_req.wdata <= wdata;
    bus_req.be    <= '1;
    cycles = 0;
    do begin
      @(negedge CLK);
      cycles++;
    end while (!bus_rsp.gnt && cycles < timeout_cycles);
    if (!bus_rsp.gnt) timeout_fail("gnt never came for the bus request");
    last_lat = cycles - 1;  // first negedge is before the sampling edge
    cycles = 0;
    do begin
      @(negedge CLK);
      cycles++;
    end while (!bus_rsp.valid && cycles < timeout_cycles);
    if (!bus_rsp.valid) timeout_fail("valid never came after gnt");
    check_eq(cycles, 1, "valid one cycle after gnt");
    rdata = bus_rsp.rdata;
    if (!keep_req) begin
      @(posedge CLK);
      bus_req.req <= 1'b0;
    end
  endtask

  task automatic bus_write(input logic [`LINT_ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
    logic [`DATA_W-1:0] unused;
    run_transfer(1'b1, addr, data, 1'b0, unused);
  endtask

  task automatic bus_read(input logic [`LINT_ADDR_W-1:0] addr, output logic [`DATA_W-1:0] data);
    run_transfer(1'b0, addr, 32'h0, 1'b0, data);
  endtask

  function automatic ram_mode_t mode_for(input int win, input lane_mode_e wm,
                                         input lane_mode_e rm);
    ram_mode_t m;
    m = '0;
    case (win)
      0: begin
        m.oper0_wmode = wm;
        m.oper0_rmode = rm;
      end
      1: begin
        m.oper1_wmode = wm;
        m.oper1_rmode = rm;
      end
      default: begin
        m.coef_wmode = wm;
        m.coef_rmode = rm;
      end
    endcase
    return m;
  endfunction

  // stored word for half and byte write modes
  function automatic logic [31:0] expect_packed(input logic is_byte, input logic [1:0] sel,
                                                input logic [31:0] d);
    logic [31:0] res;
    if (!is_byte) begin
      res = sel[1] ? {16'h0, d[31:16]} : d;
    end else begin
      case (sel)
        2'd0:    res = {24'h0, d[7:0]};
        2'd1:    res = {24'h0, d[15:8]};
        2'd2:    res = {24'h0, d[23:16]};
        default: res = {24'h0, d[31:24]};
      endcase
    end
    return res;
  endfunction

  // returned word for half and byte read modes
  function automatic logic [31:0] expect_aligned(input logic is_byte, input logic [1:0] sel,
                                                 input logic [31:0] d);
    logic [31:0] res;
    if (!is_byte) begin
      res = sel[1] ? {d[15:0], 16'h0} : d;
    end else begin
      case (sel)
        2'd0:    res = d;
        2'd1:    res = {d[23:0], 8'h0};
        2'd2:    res = {d[15:0], 16'h0};
        default: res = {d[7:0], 24'h0};
      endcase
    end
    return res;
  endfunction

  task automatic reset_state();
    logic [31:0] rd;
    logic [31:0] ctrl;
    logic [31:0] exp_status;
    @(negedge CLK);
    check_eq(bus_rsp.gnt, 1'b0, "gnt after reset");
    check_eq(bus_rsp.valid, 1'b0, "valid after reset");
    check_eq({oper0_wr.we, oper1_wr.we, coef_wr.we}, 3'b000, "we after reset");
    check_eq(bus_rsp.rdata, 32'hffffffff, "rdata after reset");
    bus_read(`REG_SIGNATURE, rd);
    check_eq(rd, 32'hca11ef3a, "signature word");
    check_eq(version, 8'h55, "version pins");
    ctrl = $urandom;
    @(posedge CLK);
    control_in <= ctrl;
    @(negedge CLK);
    exp_status = ~ctrl;
    check_eq(status_out, exp_status, "status loop-back");
  endtask

  task automatic gpio_regs();
    logic [`LINT_ADDR_W-1:0] regs [6] = '{`REG_GPIO_OUT0, `REG_GPIO_OUT1, `REG_GPIO_OUT2,
                                          `REG_GPIO_OE0, `REG_GPIO_OE1, `REG_GPIO_OE2};
    logic [31:0]        w [6];
    logic [31:0]        rd;
    logic [31:0]        ev;
    logic [31:0]        r2;
    logic [`GPIO_W-1:0] gin;
    for (int i = 0; i < 6; i++) begin
      w[i] = $urandom;
      bus_write(regs[i], w[i]);
    end
    @(negedge CLK);
    check_eq(gpio_out, {w[2][15:0], w[1], w[0]}, "gpio_out pins");
    check_eq(gpio_oe, {w[5][15:0], w[4], w[3]}, "gpio_oe pins");
    for (int i = 0; i < 6; i++) begin
      bus_read(regs[i], rd);
      check_eq(rd, (i == 2 || i == 5) ? {16'h0, w[i][15:0]} : w[i], "gpio register read back");
    end
    ev = $urandom;
    bus_write(`REG_EVENTS, ev);
    @(negedge CLK);
    check_eq(events, ev[15:0], "events pins");
    bus_read(`REG_EVENTS, rd);
    check_eq(rd, {16'h0, ev[15:0]}, "events read back");
    r2  = $urandom;
    gin = {r2[15:0], $urandom, $urandom};
    @(posedge CLK);
    gpio_in <= gin;
    bus_read(`REG_GPIO_IN0, rd);
    check_eq(rd, gin[31:0], "gpio_in word 0");
    bus_read(`REG_GPIO_IN1, rd);
    check_eq(rd, gin[63:32], "gpio_in word 1");
    bus_read(`REG_GPIO_IN2, rd);
    check_eq(rd, {16'h0, gin[79:64]}, "gpio_in word 2");
  endtask

  task automatic ram_word_loop();
    logic [31:0]             r;
    logic [31:0]             d;
    logic [31:0]             rd;
    logic [`LINT_ADDR_W-1:0] addr;
    bus_write(`REG_RAM_CTRL, 32'h0);  // all RAMs in word mode
    for (int w = 0; w < 3; w++) begin
      repeat (4) begin
        r    = $urandom;
        d    = $urandom;
        addr = {win_code[w], r[11:0]};
        bus_write(addr, d);
        bus_read(addr, rd);
        check_eq(rd, d, "word mode read back");
      end
    end
  endtask

  task automatic write_lanes();
    logic [31:0]             r;
    logic [31:0]             d;
    logic [31:0]             stored;
    logic [`LINT_ADDR_W-1:0] addr;
    lane_mode_e              lm;
    for (int w = 0; w < 3; w++) begin
      for (int m = 0; m < 2; m++) begin
        lm = (m == 0) ? lane_half : lane_byte;
        bus_write(`REG_RAM_CTRL, mode_for(w, lm, lane_word));
        for (int sel = 0; sel < 4; sel++) begin
          r    = $urandom;
          d    = $urandom;
          addr = {win_code[w], r[11:2], sel[1:0]};
          bus_write(addr, d);
          @(negedge CLK);  // model write has landed
          case (w)
            0:       stored = u_ram.oper0_mem[addr[11:0]];
            1:       stored = u_ram.oper1_mem[addr[11:0]];
            default: stored = u_ram.coef_mem[addr[11:0]];
          endcase
          check_eq(stored, expect_packed(m == 1, sel[1:0], d), "packed write lane");
        end
      end
    end
  endtask

  task automatic read_lanes();
    logic [31:0]             r;
    logic [31:0]             d;
    logic [31:0]             rd;
    logic [`LINT_ADDR_W-1:0] addr;
    lane_mode_e              lm;
    for (int w = 0; w < 3; w++) begin
      for (int m = 0; m < 2; m++) begin
        lm = (m == 0) ? lane_half : lane_byte;
        bus_write(`REG_RAM_CTRL, mode_for(w, lane_word, lm));
        for (int sel = 0; sel < 4; sel++) begin
          r    = $urandom;
          d    = $urandom;
          addr = {win_code[w], r[11:2], sel[1:0]};
          bus_write(addr, d);
          bus_read(addr, rd);
          check_eq(rd, expect_aligned(m == 1, sel[1:0], d), "aligned read lane");
        end
      end
    end
  endtask

  task automatic handshake_timing();
    logic [31:0] rd;
    logic [31:0] r;
    r = $urandom;
    bus_write(`REG_EVENTS, r);
    check_eq(last_lat, 1, "write gnt delay");
    bus_read(`REG_SIGNATURE, rd);
    check_eq(last_lat, 3, "read gnt delay");
    run_transfer(1'b0, `REG_SIGNATURE, 32'h0, 1'b1, rd);  // req stays high
    repeat (8) begin
      @(negedge CLK);
      check_eq(bus_rsp.gnt, 1'b0, "held req granted again");
      check_eq(bus_rsp.valid, 1'b0, "valid without a new request");
    end
    @(posedge CLK);
    bus_req.req <= 1'b0;
  endtask

  initial begin
    void'($urandom(32'heb8f6e9e));
    CLK         = 1'b0;
    arst_n      = 1'b0;
    bus_req     = '0;
    bus_req.wen = 1'b1;
    gpio_in     = '0;
    control_in  = '0;
    last_lat    = 0;
    repeat (10) @(posedge CLK);
    arst_n <= 1'b1;
    reset_state();
    gpio_regs();
    ram_word_loop();
    write_lanes();
    read_lanes();
    handshake_timing();
    $display("sim passed");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+include
source/lint_pkg.sv
source/lint_slave_fsm.sv
source/gpio_reg_bank.sv
source/ram_window.sv
source/efpga_test_top.sv
test/ram_model.sv
test/tb_efpga_test_top.sv
